// ==== design/fe_mem_pkg.sv ====
package fe_mem_pkg;

   // ####################################################################
   // address and data widths
   // ####################################################################

   localparam int VADDR_W     = 20;
   localparam int PADDR_W     = 20;
   localparam int PAGE_OFFS_W = 12;   // 4 KB pages.
   localparam int VTAG_W      = VADDR_W - PAGE_OFFS_W;
   localparam int PTAG_W      = PADDR_W - PAGE_OFFS_W;
   localparam int INSTR_W     = 32;
   localparam int LINE_W      = 128;  // four words.
   localparam int LINE_OFFS_W = 4;    // byte offset within a line.

   typedef logic [VADDR_W-1:0] vaddr_t;
   typedef logic [PADDR_W-1:0] paddr_t;
   typedef logic [VTAG_W-1:0]  vtag_t;
   typedef logic [PTAG_W-1:0]  ptag_t;
   typedef logic [INSTR_W-1:0] instr_t;
   typedef logic [LINE_W-1:0]  line_t;

   // ####################################################################
   // encodings
   // ####################################################################

   typedef enum logic [1:0]
   {
      op_fetch,
      op_tlb_fill,
      op_tlb_fence
   } fe_op_e;

   typedef enum logic [1:0]
   {
      priv_u = 2'd0,
      priv_s = 2'd1,
      priv_m = 2'd3
   } priv_e;

   typedef enum logic [1:0]
   {
      fill_idle,
      fill_req,
      fill_wait_drop   // ack still high from the last line.
   } fill_state_e;

   // ####################################################################
   // command, response and translation records
   // ####################################################################

   typedef struct packed
   {
      ptag_t ptag;
      logic  u;    // user page.
      logic  x;    // executable.
      logic  uc;   // uncached.
   } tlb_entry_s;

   typedef struct packed
   {
      fe_op_e     op;
      vaddr_t     vaddr;
      vtag_t      fill_vtag;
      tlb_entry_s fill_entry;
   } mem_cmd_s;

   typedef struct packed
   {
      logic   itlb_miss;
      logic   page_fault;
      logic   access_fault;
      logic   icache_miss;
      instr_t data;
   } mem_resp_s;

endpackage

// ==== design/fe_itlb.sv ====
`timescale 1ns/1ns

module fe_itlb
   import fe_mem_pkg::*;
#(
   parameter int ITLB_ELS = 4
)
(
   input  logic       clk_i,
   input  logic       rst_n_i,
   input  logic       flush_i,
   input  logic       lookup_i,
   input  logic       fill_i,
   input  vtag_t      vtag_i,
   input  tlb_entry_s entry_i,
   output logic       hit_o,
   output tlb_entry_s entry_o
);

   localparam int PTR_W = $clog2(ITLB_ELS);

   logic [ITLB_ELS-1:0] valid_r;
   vtag_t               vtag_r  [ITLB_ELS];
   tlb_entry_s          entry_r [ITLB_ELS];
   logic [PTR_W-1:0]    rr_ptr_r;

   logic [ITLB_ELS-1:0] match;
   logic [PTR_W-1:0]    match_idx;
   logic [PTR_W-1:0]    wr_idx;

   // fully associative match, shared by lookup and fill.
   always_comb
   begin
      match_idx = '0;
      for (int i = 0; i < ITLB_ELS; i++)
      begin
         match[i] = valid_r[i] && (vtag_r[i] == vtag_i);
         if (match[i])
            match_idx = PTR_W'(i);
      end
   end

   assign hit_o   = lookup_i && (|match);
   assign entry_o = entry_r[match_idx];

   // same vtag is overwritten in place.
   assign wr_idx = (|match) ? match_idx : rr_ptr_r;

   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
      begin
         valid_r  <= '0;
         rr_ptr_r <= '0;
      end
      else if (flush_i)
         valid_r <= '0;
      else if (fill_i)
      begin
         valid_r[wr_idx] <= 1'b1;
         if (!(|match))
            rr_ptr_r <= rr_ptr_r + 1'b1; // wraps, ITLB_ELS is a power of two.
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (fill_i)
      begin
         vtag_r[wr_idx]  <= vtag_i;
         entry_r[wr_idx] <= entry_i;
      end
   end

   // fe_mem only takes a fill with stage one empty.
   a_fill_not_lookup: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      !(fill_i && lookup_i));

endmodule

// ==== design/fe_icache.sv ====
`timescale 1ns/1ns

module fe_icache
   import fe_mem_pkg::*;
#(
   parameter int ICACHE_SETS = 16
)
(
   input  logic   clk_i,
   input  logic   rst_n_i,
   input  logic   lookup_i,
   input  vaddr_t vaddr_i,
   input  ptag_t  ptag_i,
   output logic   hit_o,
   output instr_t data_o,
   input  logic   alloc_i,
   input  logic   kill_i,
   output logic   idle_o,
   output logic   mem_req_o,
   output paddr_t mem_addr_o,
   input  logic   mem_ack_i,
   input  line_t  mem_data_i
);

   localparam int IDX_W = $clog2(ICACHE_SETS);
   localparam int TAG_W = PADDR_W - LINE_OFFS_W - IDX_W;

   logic [ICACHE_SETS-1:0] valid_r;
   logic [TAG_W-1:0]       tag_r  [ICACHE_SETS];
   line_t                  line_r [ICACHE_SETS];

   fill_state_e            state_r;
   paddr_t                 fill_addr_r;

   paddr_t                 lkup_paddr;
   logic [IDX_W-1:0]       lkup_idx;
   logic [TAG_W-1:0]       lkup_tag;
   logic [1:0]             lkup_word;
   logic                   lkup_hit;
   logic [IDX_W-1:0]       fill_idx;
   logic                   start_fill;
   logic                   line_done;

   // ####################################################################
   // lookup
   // ####################################################################

   // index bits sit inside the page offset, so vaddr and paddr agree there.
   assign lkup_paddr = {ptag_i, vaddr_i[PAGE_OFFS_W-1:0]};
   assign lkup_idx   = vaddr_i[LINE_OFFS_W +: IDX_W];
   assign lkup_word  = vaddr_i[LINE_OFFS_W-1:2];
   assign lkup_tag   = lkup_paddr[PADDR_W-1 -: TAG_W];
   assign lkup_hit   = valid_r[lkup_idx] && (tag_r[lkup_idx] == lkup_tag);

   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
         hit_o <= 1'b0;
      else
         hit_o <= lookup_i && lkup_hit;
   end

   always_ff @(posedge clk_i)
   begin
      if (lookup_i)
         data_o <= line_r[lkup_idx][lkup_word*INSTR_W +: INSTR_W];
   end

   // ####################################################################
   // line fill, four-phase req/ack
   // ####################################################################

   assign idle_o     = (state_r == fill_idle);
   assign mem_req_o  = (state_r == fill_req);
   assign mem_addr_o = fill_addr_r;

   assign start_fill = idle_o && lookup_i && alloc_i && !kill_i && !lkup_hit;
   assign line_done  = mem_req_o && mem_ack_i;
   assign fill_idx   = fill_addr_r[LINE_OFFS_W +: IDX_W];

   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
         state_r <= fill_idle;
      else
      begin
         case (state_r)
            fill_idle:
               if (start_fill)
                  state_r <= fill_req;
            fill_req:
               if (mem_ack_i)
                  state_r <= fill_wait_drop; // data taken, drop req.
            fill_wait_drop:
               if (!mem_ack_i)
                  state_r <= fill_idle;
            default:
               state_r <= fill_idle;
         endcase
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
         valid_r <= '0;
      else if (line_done)
         valid_r[fill_idx] <= 1'b1;
   end

   always_ff @(posedge clk_i)
   begin
      if (start_fill)
         fill_addr_r <= {lkup_paddr[PADDR_W-1:LINE_OFFS_W], {LINE_OFFS_W{1'b0}}};
      if (line_done)
      begin
         tag_r[fill_idx]  <= fill_addr_r[PADDR_W-1 -: TAG_W];
         line_r[fill_idx] <= mem_data_i;
      end
   end

   // the memory must answer before the request goes away.
   a_req_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      mem_req_o && !mem_ack_i |=> mem_req_o);

endmodule

// ==== design/fe_mem.sv ====
`timescale 1ns/1ns

module fe_mem
   import fe_mem_pkg::*;
#(
   parameter int ITLB_ELS    = 4,
   parameter int ICACHE_SETS = 16
)
(
   input  logic      clk_i,
   input  logic      rst_n_i,
   input  mem_cmd_s  cmd_i,
   input  logic      cmd_v_i,
   output logic      cmd_yumi_o,
   input  priv_e     priv_i,
   input  logic      poison_i,
   output mem_resp_s resp_o,
   output logic      resp_v_o,
   input  logic      resp_ready_i,
   output logic      mem_req_o,
   output paddr_t    mem_addr_o,
   input  logic      mem_ack_i,
   input  line_t     mem_data_i
);

   logic       take_fetch;
   logic       take_fill;
   logic       take_fence;

   logic       s1_v_r;
   vaddr_t     s1_vaddr_r;
   priv_e      s1_priv_r;
   vtag_t      tlb_vtag;
   logic       tlb_hit;
   tlb_entry_s tlb_entry;
   logic       priv_bad;
   logic       s1_page_fault;
   logic       alloc;

   logic       s2_v_r;
   logic       s2_itlb_miss_r;
   logic       s2_page_fault_r;
   logic       s2_access_fault_r;
   logic       s2_clean;
   logic       icache_hit;
   instr_t     icache_data;
   logic       icache_idle;

   // ####################################################################
   // command accept
   // ####################################################################

   assign cmd_yumi_o = cmd_v_i && !s1_v_r && !s2_v_r && !resp_v_o && icache_idle;

   assign take_fetch = cmd_yumi_o && (cmd_i.op == op_fetch);
   assign take_fill  = cmd_yumi_o && (cmd_i.op == op_tlb_fill);
   assign take_fence = cmd_yumi_o && (cmd_i.op == op_tlb_fence);

   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
         s1_v_r <= 1'b0;
      else
         s1_v_r <= take_fetch;
   end

   always_ff @(posedge clk_i)
   begin
      if (take_fetch)
      begin
         s1_vaddr_r <= cmd_i.vaddr;
         s1_priv_r  <= priv_i;
      end
   end

   // ####################################################################
   // stage one: translate, check, look up the cache
   // ####################################################################

   assign tlb_vtag = take_fill ? cmd_i.fill_vtag : s1_vaddr_r[VADDR_W-1 -: VTAG_W];

   fe_itlb #(
      .ITLB_ELS (ITLB_ELS)
   ) i_itlb (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .flush_i  (take_fence),
      .lookup_i (s1_v_r),
      .fill_i   (take_fill),
      .vtag_i   (tlb_vtag),
      .entry_i  (cmd_i.fill_entry),
      .hit_o    (tlb_hit),
      .entry_o  (tlb_entry)
   );

   // machine mode is never checked.
   assign priv_bad = ((s1_priv_r == priv_u) && !tlb_entry.u)
                  || ((s1_priv_r == priv_s) && tlb_entry.u);
   assign s1_page_fault = !tlb_entry.x || priv_bad;
   assign alloc = s1_v_r && tlb_hit && !s1_page_fault && !tlb_entry.uc;

   fe_icache #(
      .ICACHE_SETS (ICACHE_SETS)
   ) i_icache (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .lookup_i   (s1_v_r),
      .vaddr_i    (s1_vaddr_r),
      .ptag_i     (tlb_entry.ptag),
      .hit_o      (icache_hit),
      .data_o     (icache_data),
      .alloc_i    (alloc),
      .kill_i     (poison_i),
      .idle_o     (icache_idle),
      .mem_req_o  (mem_req_o),
      .mem_addr_o (mem_addr_o),
      .mem_ack_i  (mem_ack_i),
      .mem_data_i (mem_data_i)
   );

   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
         s2_v_r <= 1'b0;
      else
         s2_v_r <= s1_v_r && !poison_i; // poisoned fetch vanishes here.
   end

   // a tlb miss masks the other faults.
   always_ff @(posedge clk_i)
   begin
      s2_itlb_miss_r    <= !tlb_hit;
      s2_page_fault_r   <= tlb_hit && s1_page_fault;
      s2_access_fault_r <= tlb_hit && tlb_entry.uc;
   end

   // ####################################################################
   // stage two: build and hold the response
   // ####################################################################

   assign s2_clean = !s2_itlb_miss_r && !s2_page_fault_r && !s2_access_fault_r;

   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
         resp_v_o <= 1'b0;
      else if (s2_v_r)
         resp_v_o <= 1'b1;
      else if (resp_ready_i)
         resp_v_o <= 1'b0;
   end

   always_ff @(posedge clk_i)
   begin
      if (s2_v_r)
      begin
         resp_o.itlb_miss    <= s2_itlb_miss_r;
         resp_o.page_fault   <= s2_page_fault_r;
         resp_o.access_fault <= s2_access_fault_r;
         resp_o.icache_miss  <= s2_clean && !icache_hit;
         resp_o.data         <= (s2_clean && icache_hit) ? icache_data : '0;
      end
   end

   a_resp_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      resp_v_o && !resp_ready_i |=> resp_v_o && $stable(resp_o));

endmodule

// ==== verif/mem_responder.sv ====
`timescale 1ns/1ns

module mem_responder
   import fe_mem_pkg::*;
#(
   parameter logic [31:0] WORD_MUL = 32'h9E37_79B1
)
(
   input  logic   clk_i,
   input  logic   rst_n_i,
   input  logic   req_i,
   input  paddr_t addr_i,
   output logic   ack_o,
   output line_t  data_o
);

   logic       busy_r;
   logic [2:0] wait_r;

   // four-phase slave, 1 to 6 cycles from request to acknowledge.
   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
      begin
         ack_o  <= 1'b0;
         busy_r <= 1'b0;
      end
      else if (ack_o)
      begin
         if (!req_i)
            ack_o <= 1'b0; // request dropped, release.
      end
      else if (req_i)
      begin
         if (!busy_r)
         begin
            busy_r <= 1'b1;
            wait_r <= 3'($urandom_range(5, 0));
         end
         else if (wait_r == 3'd0)
         begin
            busy_r <= 1'b0;
            ack_o  <= 1'b1;
            for (int w = 0; w < 4; w++)
               data_o[w*INSTR_W +: INSTR_W] <= 32'((addr_i >> 2) + w) * WORD_MUL;
         end
         else
            wait_r <= wait_r - 3'd1;
      end
   end

endmodule

// ==== verif/fe_mem_checks.svh ====
`ifndef FE_MEM_CHECKS_SVH
`define FE_MEM_CHECKS_SVH

// one compare task per kind of result.

task automatic check_resp(string name, mem_resp_s act, mem_resp_s exp);
   if (act !== exp)
   begin
      $display("Error at %0t ns: %s = %h, expected %h", $time, name, act, exp);
      $display("   flags act m/pf/af/cm = %b%b%b%b, exp = %b%b%b%b",
               act.itlb_miss, act.page_fault, act.access_fault, act.icache_miss,
               exp.itlb_miss, exp.page_fault, exp.access_fault, exp.icache_miss);
      abort_run();
   end
endtask

task automatic check_mem_addr(string name, paddr_t act, paddr_t exp);
   if (act !== exp)
   begin
      $display("Error at %0t ns: %s = %h, expected %h", $time, name, act, exp);
      abort_run();
   end
endtask

`endif

// ==== verif/fe_mem_tb.sv ====
`timescale 1ns/1ns

module fe_mem_tb
   import fe_mem_pkg::*;
();

   localparam int          ITLB_ELS     = 4;
   localparam int          ICACHE_SETS  = 16;
   localparam int          RESET_CYCLES = 5;
   localparam int          NUM_CMDS     = 400;
   localparam int          CYCLE_LIMIT  = NUM_CMDS * 12 + RESET_CYCLES;
   localparam int unsigned SEED         = 54777;
   localparam logic [31:0] WORD_MUL     = 32'h9E37_79B1;  // odd.
   localparam int          TAG_SHIFT    = LINE_OFFS_W + $clog2(ICACHE_SETS);

   logic      clk_i;
   logic      rst_n_i;
   mem_cmd_s  cmd_i;
   logic      cmd_v_i;
   logic      cmd_yumi_o;
   priv_e     priv_i;
   logic      poison_i;
   mem_resp_s resp_o;
   logic      resp_v_o;
   logic      resp_ready_i;
   logic      mem_req_o;
   paddr_t    mem_addr_o;
   logic      mem_ack_i;
   line_t     mem_data_i;

   // reference model state.
   logic       m_tlb_v    [ITLB_ELS];
   vtag_t      m_tlb_vtag [ITLB_ELS];
   tlb_entry_s m_tlb_e    [ITLB_ELS];
   int         m_rr;
   logic       m_line_v   [ICACHE_SETS];
   int         m_line_tag [ICACHE_SETS];

   int        cyc;
   int        cmds_taken;
   int        fetch_cyc;
   int        fill_exp_cyc;
   logic      fetch_live;
   logic      fetch_fill;
   logic      fill_expected;
   logic      resp_held;
   logic      req_seen;
   logic      run_done;
   mem_resp_s fetch_exp;
   mem_resp_s resp_hold_val;
   paddr_t    fetch_fill_addr;
   paddr_t    fill_exp_addr;

   fe_mem #(
      .ITLB_ELS    (ITLB_ELS),
      .ICACHE_SETS (ICACHE_SETS)
   ) i_dut (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .cmd_i        (cmd_i),
      .cmd_v_i      (cmd_v_i),
      .cmd_yumi_o   (cmd_yumi_o),
      .priv_i       (priv_i),
      .poison_i     (poison_i),
      .resp_o       (resp_o),
      .resp_v_o     (resp_v_o),
      .resp_ready_i (resp_ready_i),
      .mem_req_o    (mem_req_o),
      .mem_addr_o   (mem_addr_o),
      .mem_ack_i    (mem_ack_i),
      .mem_data_i   (mem_data_i)
   );

   mem_responder #(
      .WORD_MUL (WORD_MUL)
   ) i_mem (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .req_i   (mem_req_o),
      .addr_i  (mem_addr_o),
      .ack_o   (mem_ack_i),
      .data_o  (mem_data_i)
   );

   initial clk_i = 1'b0;
   always #20 clk_i = ~clk_i;

   task automatic abort_run();
      $display("Simulation failed");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic report_failure(string what);
      $display("%0t ns: %s", $time, what);
      abort_run();
   endtask

   `include "fe_mem_checks.svh"

   // ####################################################################
   // reference model
   // ####################################################################

   function automatic instr_t expected_word(paddr_t a);
      return instr_t'((a >> 2) * WORD_MUL);
   endfunction

   task automatic model_tlb_fill(vtag_t vt, tlb_entry_s e);
      int slot;
      slot = -1;
      for (int i = 0; i < ITLB_ELS; i++)
         if (m_tlb_v[i] && (m_tlb_vtag[i] == vt))
            slot = i;
      if (slot < 0)
      begin
         slot = m_rr;
         m_rr = (m_rr + 1) % ITLB_ELS;
      end
      m_tlb_v[slot]    = 1'b1;
      m_tlb_vtag[slot] = vt;
      m_tlb_e[slot]    = e;
   endtask

   task automatic model_tlb_fence();
      for (int i = 0; i < ITLB_ELS; i++)
         m_tlb_v[i] = 1'b0; // pointer keeps its place.
   endtask

   task automatic install_line(paddr_t a);
      int idx;
      idx = int'(a >> LINE_OFFS_W) % ICACHE_SETS;
      m_line_v[idx]   = 1'b1;
      m_line_tag[idx] = int'(a >> TAG_SHIFT);
   endtask

   task automatic predict_fetch(vaddr_t va, priv_e pv);
      int         slot;
      int         idx;
      tlb_entry_s e;
      paddr_t     pa;
      logic       pf;
      logic       clean;
      logic       present;
      slot       = -1;
      fetch_exp  = '0;
      fetch_fill = 1'b0;
      for (int i = 0; i < ITLB_ELS; i++)
         if (m_tlb_v[i] && (m_tlb_vtag[i] == va[VADDR_W-1 -: VTAG_W]))
            slot = i;
      if (slot < 0)
         fetch_exp.itlb_miss = 1'b1;
      else
      begin
         e       = m_tlb_e[slot];
         pa      = {e.ptag, va[PAGE_OFFS_W-1:0]};
         pf      = !e.x || ((pv == priv_u) && !e.u) || ((pv == priv_s) && e.u);
         clean   = !pf && !e.uc;
         idx     = int'(pa >> LINE_OFFS_W) % ICACHE_SETS;
         present = m_line_v[idx] && (m_line_tag[idx] == int'(pa >> TAG_SHIFT));
         fetch_exp.page_fault   = pf;
         fetch_exp.access_fault = e.uc;
         fetch_exp.icache_miss  = clean && !present;
         if (clean && present)
            fetch_exp.data = expected_word(pa);
         fetch_fill      = clean && !present;
         fetch_fill_addr = {pa[PADDR_W-1:LINE_OFFS_W], {LINE_OFFS_W{1'b0}}};
      end
   endtask

   // ####################################################################
   // stimulus
   // ####################################################################

   function automatic vtag_t pick_page();
      case ($urandom_range(5, 0))
         0:       return 8'h00;
         1:       return 8'h01;
         2:       return 8'h05;
         3:       return 8'h3c;
         4:       return 8'h80;
         default: return 8'hff;
      endcase
   endfunction

   function automatic priv_e pick_priv();
      case ($urandom_range(2, 0))
         0:       return priv_u;
         1:       return priv_s;
         default: return priv_m;
      endcase
   endfunction

   function automatic mem_cmd_s make_cmd();
      mem_cmd_s    c;
      int unsigned sel;
      c   = '0;
      sel = $urandom_range(9, 0);
      if (sel < 6)
         c.op = op_fetch;
      else if (sel < 9)
         c.op = op_tlb_fill;
      else
         c.op = op_tlb_fence;
      // 24 lines per page, so set indexes collide.
      c.vaddr = {pick_page(), 8'($urandom_range(23, 0)), 2'($urandom_range(3, 0)), 2'b00};
      c.fill_vtag       = pick_page();
      c.fill_entry.ptag = ptag_t'($urandom_range(15, 0));
      c.fill_entry.u    = 1'($urandom_range(1, 0));
      c.fill_entry.x    = ($urandom_range(9, 0) != 0);
      c.fill_entry.uc   = ($urandom_range(9, 0) == 0);
      return c;
   endfunction

   task automatic drive_inputs();
      if (cmds_taken >= NUM_CMDS)
         cmd_v_i <= 1'b0;
      else if (!cmd_v_i || cmd_yumi_o)
      begin
         cmd_i   <= make_cmd();
         priv_i  <= pick_priv();
         cmd_v_i <= ($urandom_range(9, 0) != 0);
      end
      poison_i     <= ($urandom_range(9, 0) == 0);
      resp_ready_i <= ($urandom_range(9, 0) < 7);
   endtask

   // ####################################################################
   // checking on values sampled at the edge
   // ####################################################################

   task automatic observe_edge();
      if (cmd_yumi_o && (mem_req_o || mem_ack_i))
         report_failure("a command was taken during a cache line fill");

      // memory port.
      if (mem_req_o && !req_seen)
      begin
         if (!fill_expected)
            report_failure("memory request without a preceding cache miss");
         check_mem_addr("mem_addr_o", mem_addr_o, fill_exp_addr);
         fill_expected = 1'b0;
      end
      if (fill_expected && (cyc >= fill_exp_cyc + 1))
         report_failure("a cache miss did not start a memory request");
      if (mem_req_o && mem_ack_i)
         install_line(fill_exp_addr);
      req_seen = mem_req_o;

      // poison is sampled one edge after the fetch.
      if (fetch_live && (cyc == fetch_cyc + 1))
      begin
         if (poison_i)
            fetch_live = 1'b0;
         else if (fetch_fill)
         begin
            fill_expected = 1'b1;
            fill_exp_addr = fetch_fill_addr;
            fill_exp_cyc  = cyc;
         end
      end

      // response port.
      if (resp_v_o)
      begin
         if (cmd_yumi_o)
            report_failure("a command was taken while a response was held");
         if (!resp_held)
         begin
            if (!fetch_live || (cyc != fetch_cyc + 3))
               report_failure("a response appeared at the wrong edge");
            check_resp("resp_o", resp_o, fetch_exp);
            resp_held = 1'b1;
         end
         else
            check_resp("resp_o (held)", resp_o, resp_hold_val);
         resp_hold_val = resp_o;
         if (resp_ready_i)
         begin
            resp_held  = 1'b0;
            fetch_live = 1'b0;
         end
      end
      else if (fetch_live && (cyc >= fetch_cyc + 3))
         report_failure("an expected response is missing or was dropped");

      // command port.
      if (cmd_v_i && cmd_yumi_o)
      begin
         cmds_taken++;
         case (cmd_i.op)
            op_fetch:
            begin
               predict_fetch(cmd_i.vaddr, priv_i);
               fetch_live = 1'b1;
               fetch_cyc  = cyc;
            end
            op_tlb_fill:
               model_tlb_fill(cmd_i.fill_vtag, cmd_i.fill_entry);
            default:
               model_tlb_fence();
         endcase
      end

      if ((cmds_taken >= NUM_CMDS) && !fetch_live && !fill_expected
          && !mem_req_o && !mem_ack_i)
         run_done = 1'b1;
   endtask

   initial
   begin
      void'($urandom(SEED));
      rst_n_i       = 1'b0;
      cmd_v_i       = 1'b0;
      cmd_i         = '0;
      priv_i        = priv_m;
      poison_i      = 1'b0;
      resp_ready_i  = 1'b0;
      cyc           = 0;
      cmds_taken    = 0;
      fetch_cyc     = 0;
      fill_exp_cyc  = 0;
      fetch_live    = 1'b0;
      fetch_fill    = 1'b0;
      fill_expected = 1'b0;
      resp_held     = 1'b0;
      req_seen      = 1'b0;
      run_done      = 1'b0;
      m_rr          = 0;
      for (int i = 0; i < ITLB_ELS; i++)
         m_tlb_v[i] = 1'b0;
      for (int i = 0; i < ICACHE_SETS; i++)
         m_line_v[i] = 1'b0;

      while (!run_done)
      begin
         @(posedge clk_i);
         cyc++;
         if (cyc > CYCLE_LIMIT)
            report_failure("timeout, the command stream did not finish in time");
         if (cyc == RESET_CYCLES)
            rst_n_i <= 1'b1;
         else if (cyc > RESET_CYCLES)
         begin
            observe_edge();
            drive_inputs();
         end
      end

      $display("Simulation completed successfully");
      $finish;
   end

endmodule

// ==== flist.f ====
+incdir+verif
design/fe_mem_pkg.sv
design/fe_itlb.sv
design/fe_icache.sv
design/fe_mem.sv
verif/mem_responder.sv
verif/fe_mem_tb.sv
